//--- dv/fwrisc_branch_tb.sv
`timescale 1ns/1ns

module fwrisc_branch_tb;

	localparam int clock_period = 100;
	localparam int reset_cycles = 8;
	localparam int fixed_rows = 16;
	localparam int random_rows = 4;
	localparam int num_rows = fixed_rows + random_rows;

	// Negedges from the drive edge to the completion pulse, for every row.
	localparam int issue_cycles = 4;
	localparam int wait_limit = 16;
	localparam int watchdog_ns = 2 * (reset_cycles + num_rows * 6) * clock_period;

	logic clock;
	logic reset;
	logic [1:0] op_sel;
	logic cond;
	logic [fwrisc_pkg::xlen-1:0] value;
	logic [fwrisc_pkg::branch_width-1:0] branch;
	logic [fwrisc_pkg::xlen-1:0] pc;
	logic instr_complete;

	// Stimulus table, one branch per row.
	string name_tab [num_rows];
	logic [1:0] op_sel_tab [num_rows];
	logic cond_tab [num_rows];
	logic [fwrisc_pkg::xlen-1:0] value_tab [num_rows];
	logic [fwrisc_pkg::branch_width-1:0] branch_tab [num_rows];

	fwrisc_branch_top fwrisc_branch_top_i (
		.clock(clock),
		.reset(reset),
		.op_sel(op_sel),
		.cond(cond),
		.value(value),
		.branch(branch),
		.pc(pc),
		.instr_complete(instr_complete)
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		#(watchdog_ns);
		$display("ERROR: watchdog expired after %0d ns before the tests finished", watchdog_ns);
		$display("tests failed");
		$fatal(1, "simulation stopped by watchdog");
	end

	task automatic stop_with_error(input string reason);
		$display("ERROR: %s", reason);
		$display("tests failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_pc(
		input string test_name,
		input logic [fwrisc_pkg::xlen-1:0] expected,
		input logic [fwrisc_pkg::xlen-1:0] actual
	);
		if (actual !== expected) begin
			$display("[FAIL] %s: pc expected %h, actual %h", test_name, expected, actual);
			$display("tests failed");
			$fatal(1, "simulation stopped on pc mismatch");
		end
	endtask

	task automatic check_complete(
		input string test_name,
		input logic expected,
		input logic actual
	);
		if (actual !== expected) begin
			$display("[FAIL] %s: instr_complete expected %b, actual %b",
				test_name, expected, actual);
			$display("tests failed");
			$fatal(1, "simulation stopped on completion mismatch");
		end
	endtask

	task automatic set_row(
		input int idx,
		input string test_name,
		input logic [1:0] sel,
		input logic c,
		input logic [fwrisc_pkg::xlen-1:0] val,
		input logic [fwrisc_pkg::branch_width-1:0] br
	);
		name_tab[idx] = test_name;
		op_sel_tab[idx] = sel;
		cond_tab[idx] = c;
		value_tab[idx] = val;
		branch_tab[idx] = br;
	endtask

	task automatic load_table();
		int k;
		set_row(0, "eq_taken", 2'd0, 1'b1, 32'h1234_5678, 12'h010);
		set_row(1, "eq_not_taken", 2'd0, 1'b0, 32'hdead_beef, 12'h020);
		set_row(2, "eq_zero_not_taken", 2'd0, 1'b0, 32'h0000_0000, 12'h004);
		set_row(3, "eq_ones_not_taken", 2'd0, 1'b0, 32'hffff_ffff, 12'h008);
		set_row(4, "lt_taken", 2'd1, 1'b1, 32'h0000_0005, 12'h040);
		set_row(5, "lt_negative_taken", 2'd1, 1'b1, 32'hffff_fff0, 12'h0c0);
		set_row(6, "lt_wrap_not_taken", 2'd1, 1'b1, 32'h7fff_ffff, 12'h100);
		set_row(7, "lt_not_taken", 2'd1, 1'b0, 32'h8000_0000, 12'h010);
		set_row(8, "ltu_taken", 2'd2, 1'b1, 32'h0000_1000, 12'h200);
		set_row(9, "ltu_wrap_not_taken", 2'd2, 1'b1, 32'hffff_ffff, 12'h300);
		set_row(10, "ltu_not_taken", 2'd2, 1'b0, 32'h0000_0055, 12'h020);
		set_row(11, "zero_offset", 2'd0, 1'b1, 32'h0000_a5a5, 12'h000);
		set_row(12, "negative_offset", 2'd1, 1'b1, 32'h0000_0064, 12'hff0);
		set_row(13, "most_negative_offset", 2'd2, 1'b1, 32'h0000_0000, 12'h800);
		set_row(14, "sel3_folds_to_eq", 2'd3, 1'b1, 32'h0bad_cafe, 12'h7ff);
		set_row(15, "sel3_not_taken", 2'd3, 1'b0, 32'h1357_9bdf, 12'hfff);
		for (k = 0; k < random_rows; k++) begin
			set_row(fixed_rows + k, $sformatf("random_%0d", k), 2'($urandom),
				1'($urandom), $urandom, 12'($urandom));
		end
	endtask

	// Next pc from the branch rules, with the outcome taken from the real comparison.
	function automatic logic [fwrisc_pkg::xlen-1:0] predict_next_pc(
		input logic [fwrisc_pkg::xlen-1:0] cur_pc,
		input logic [1:0] sel,
		input logic c,
		input logic [fwrisc_pkg::xlen-1:0] val,
		input logic [fwrisc_pkg::branch_width-1:0] br
	);
		int kind;
		logic [fwrisc_pkg::branch_width-1:0] field;
		logic [fwrisc_pkg::xlen-1:0] offset;
		logic [fwrisc_pkg::xlen-1:0] b;
		logic is_taken;
		kind = int'(sel) % 3;
		field = (br == 12'd0) ? 12'd1 : br;
		offset = {{(fwrisc_pkg::xlen - fwrisc_pkg::branch_width){field[11]}}, field};
		offset = offset << 1;
		if (kind == 0) begin
			b = c ? val : ~val;
			is_taken = (val == b);
		end else if (kind == 1) begin
			b = c ? val + 32'd1 : val;
			is_taken = ($signed(val) < $signed(b));
		end else begin
			b = c ? val + 32'd1 : val;
			is_taken = (val < b);
		end
		if (is_taken) begin
			return cur_pc + offset;
		end else begin
			return cur_pc + fwrisc_pkg::instr_bytes;
		end
	endfunction

	task automatic drive_row(input int idx);
		op_sel <= op_sel_tab[idx];
		cond <= cond_tab[idx];
		value <= value_tab[idx];
		branch <= branch_tab[idx];
	endtask

	initial begin : main
		int cycles;
		logic [fwrisc_pkg::xlen-1:0] expected_pc;

		reset = 1'b1;
		op_sel = 2'd0;
		cond = 1'b0;
		value = '0;
		branch = '0;
		void'($urandom(35305));
		load_table();
		expected_pc = fwrisc_pkg::reset_pc;

		repeat (reset_cycles - 1) @(posedge clock);
		@(negedge clock);
		check_pc("after_reset", fwrisc_pkg::reset_pc, pc);
		check_complete("after_reset", 1'b0, instr_complete);

		// The last reset edge also loads the first row, which is sampled on the next edge.
		@(posedge clock);
		reset <= 1'b0;
		drive_row(0);

		for (int i = 0; i < num_rows; i++) begin
			@(negedge clock);
			check_complete(name_tab[i], 1'b0, instr_complete);
			cycles = 1;
			while (instr_complete !== 1'b1) begin
				@(negedge clock);
				cycles = cycles + 1;
				if (cycles > wait_limit) begin
					stop_with_error($sformatf("%s: no completion within %0d cycles",
						name_tab[i], wait_limit));
				end
			end
			expected_pc = predict_next_pc(expected_pc, op_sel_tab[i], cond_tab[i],
				value_tab[i], branch_tab[i]);
			check_pc(name_tab[i], expected_pc, pc);
			if (cycles != issue_cycles) begin
				stop_with_error($sformatf("%s: completion came after %0d cycles, expected %0d",
					name_tab[i], cycles, issue_cycles));
			end
			@(posedge clock);
			if (i + 1 < num_rows) begin
				drive_row(i + 1);
			end
		end

		// The last pulse must also end after one cycle.
		@(negedge clock);
		check_complete("final_pulse", 1'b0, instr_complete);

		$display("all tests passed");
		$finish;
	end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns -f verilog.f \
	--top-module fwrisc_branch_tb -o fwrisc_branch_sim

status=0
./obj_dir/fwrisc_branch_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation PASSED"

//--- src/fwrisc_branch_stim.sv
`timescale 1ns/1ns

module fwrisc_branch_stim (
	input logic clock,
	input logic reset,
	input logic instr_complete,
	input logic [1:0] op_sel,
	input logic cond,
	input logic [fwrisc_pkg::xlen-1:0] value,
	input logic [fwrisc_pkg::branch_width-1:0] branch,
	output logic decode_valid,
	output logic [fwrisc_pkg::op_width-1:0] op,
	output logic [fwrisc_pkg::xlen-1:0] op_a,
	output logic [fwrisc_pkg::xlen-1:0] op_b,
	output logic [fwrisc_pkg::xlen-1:0] op_c
);

	logic state;
	logic decode_valid_r;

	logic [1:0] op_idx;
	logic [fwrisc_pkg::branch_width-1:0] branch_nz;
	logic [fwrisc_pkg::xlen-1:0] value_inc;
	logic [fwrisc_pkg::op_width-1:0] op_next;
	logic [fwrisc_pkg::xlen-1:0] op_b_next;
	logic [fwrisc_pkg::xlen-1:0] op_c_next;

	// The selector is taken modulo 3, so a value of 3 folds back onto EQ.
	assign op_idx = (op_sel == 2'd3) ? 2'd0 : op_sel;

	// A zero offset would branch onto itself, so the smallest step is used instead.
	assign branch_nz = (branch != '0) ? branch : {{(fwrisc_pkg::branch_width-1){1'b0}}, 1'b1};

	// Sign-extend the offset and scale it to a byte offset in half-words.
	assign op_c_next = {
		{(fwrisc_pkg::xlen-fwrisc_pkg::branch_width-1){branch_nz[fwrisc_pkg::branch_width-1]}},
		branch_nz,
		1'b0
	};

	// Wraps at the top of the range, which is what the model expects.
	assign value_inc = value + {{(fwrisc_pkg::xlen-1){1'b0}}, 1'b1};

	// Pick the operands so that the comparison gives the outcome that cond asks for.
	always_comb begin
		case (op_idx)
			2'd0: begin
				op_next = fwrisc_pkg::op_eq;
				op_b_next = cond ? value : ~value;
			end
			2'd1: begin
				op_next = fwrisc_pkg::op_lt;
				op_b_next = cond ? value_inc : value;
			end
			default: begin
				op_next = fwrisc_pkg::op_ltu;
				op_b_next = cond ? value_inc : value;
			end
		endcase
	end

	// Issue one branch, then hold it until the execute stage reports completion.
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fwrisc_pkg::stim_idle;
			decode_valid_r <= 1'b0;
		end else begin
			case (state)
				fwrisc_pkg::stim_idle: begin
					decode_valid_r <= 1'b1;
					state <= fwrisc_pkg::stim_wait;
				end
				fwrisc_pkg::stim_wait: begin
					if (instr_complete) begin
						decode_valid_r <= 1'b0;
						state <= fwrisc_pkg::stim_idle;
					end
				end
			endcase
		end
	end

	// The instruction fields load only in idle, so they stay put while valid is up.
	always_ff @(posedge clock) begin
		if (state == fwrisc_pkg::stim_idle) begin
			op <= op_next;
			op_a <= value;
			op_b <= op_b_next;
			op_c <= op_c_next;
		end
	end

	// Valid drops in the completion cycle so the same branch is not taken twice.
	assign decode_valid = decode_valid_r & ~instr_complete;

endmodule

//--- src/fwrisc_branch_top.sv
`timescale 1ns/1ns

module fwrisc_branch_top (
	input logic clock,
	input logic reset,
	input logic [1:0] op_sel,
	input logic cond,
	input logic [fwrisc_pkg::xlen-1:0] value,
	input logic [fwrisc_pkg::branch_width-1:0] branch,
	output logic [fwrisc_pkg::xlen-1:0] pc,
	output logic instr_complete
);

	// Decoded branch from the stimulus block into execute.
	logic decode_valid;
	logic [fwrisc_pkg::op_width-1:0] op;
	logic [fwrisc_pkg::xlen-1:0] op_a;
	logic [fwrisc_pkg::xlen-1:0] op_b;
	logic [fwrisc_pkg::xlen-1:0] op_c;

	fwrisc_branch_stim u_stim (
		.clock(clock),
		.reset(reset),
		.instr_complete(instr_complete),
		.op_sel(op_sel),
		.cond(cond),
		.value(value),
		.branch(branch),
		.decode_valid(decode_valid),
		.op(op),
		.op_a(op_a),
		.op_b(op_b),
		.op_c(op_c)
	);

	// Completion goes both to the top port and back to the stimulus block.
	fwrisc_exec_branch u_exec (
		.clock(clock),
		.reset(reset),
		.decode_valid(decode_valid),
		.op(op),
		.op_a(op_a),
		.op_b(op_b),
		.op_c(op_c),
		.pc(pc),
		.instr_complete(instr_complete)
	);

endmodule

//--- src/fwrisc_exec_branch.sv
`timescale 1ns/1ns

module fwrisc_exec_branch (
	input logic clock,
	input logic reset,
	input logic decode_valid,
	input logic [fwrisc_pkg::op_width-1:0] op,
	input logic [fwrisc_pkg::xlen-1:0] op_a,
	input logic [fwrisc_pkg::xlen-1:0] op_b,
	input logic [fwrisc_pkg::xlen-1:0] op_c,
	output logic [fwrisc_pkg::xlen-1:0] pc,
	output logic instr_complete
);

	logic state;

	// Raw comparison results.
	logic cmp_eq;
	logic cmp_lt;
	logic cmp_ltu;
	logic taken;

	// Resolution recorded in the first cycle and consumed in the second.
	logic taken_q;
	logic [fwrisc_pkg::xlen-1:0] target;
	logic [fwrisc_pkg::xlen-1:0] target_q;

	// Candidate program counter values.
	logic [fwrisc_pkg::xlen-1:0] seq_pc;
	logic [fwrisc_pkg::xlen-1:0] next_pc;

	assign cmp_eq = (op_a == op_b);
	assign cmp_lt = ($signed(op_a) < $signed(op_b));
	assign cmp_ltu = (op_a < op_b);

	// Anything other than the three resolved codes falls through.
	always_comb begin
		case (op)
			fwrisc_pkg::op_eq: taken = cmp_eq;
			fwrisc_pkg::op_lt: taken = cmp_lt;
			fwrisc_pkg::op_ltu: taken = cmp_ltu;
			default: taken = 1'b0;
		endcase
	end

	// The offset is relative to the address of the branch itself.
	assign target = pc + op_c;
	assign seq_pc = pc + fwrisc_pkg::instr_bytes;
	assign next_pc = taken_q ? target_q : seq_pc;

	// Resolve on the edge that sees valid, commit on the one after.
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fwrisc_pkg::exec_idle;
			pc <= fwrisc_pkg::reset_pc;
			instr_complete <= 1'b0;
			taken_q <= 1'b0;
		end else begin
			instr_complete <= 1'b0;
			case (state)
				fwrisc_pkg::exec_idle: begin
					if (decode_valid) begin
						taken_q <= taken;
						state <= fwrisc_pkg::exec_commit;
					end
				end
				fwrisc_pkg::exec_commit: begin
					pc <= next_pc;
					instr_complete <= 1'b1;
					state <= fwrisc_pkg::exec_idle;
				end
			endcase
		end
	end

	// The taken target is captured alongside the outcome.
	always_ff @(posedge clock) begin
		if (state == fwrisc_pkg::exec_idle && decode_valid) begin
			target_q <= target;
		end
	end

endmodule

//--- src/fwrisc_pkg.sv
package fwrisc_pkg;

	// Data and address width of the core.
	localparam int xlen = 32;

	// Width of the operation code driven from decode into execute.
	localparam int op_width = 6;

	// Branch comparison codes.
	// The odd codes are kept free for the inverted forms (NE, GE, GEU),
	// which this execute stage does not resolve.
	localparam logic [op_width-1:0] op_eq = 6'd0;
	localparam logic [op_width-1:0] op_lt = 6'd2;
	localparam logic [op_width-1:0] op_ltu = 6'd4;

	// Program counter after reset.
	localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

	// Step taken by the program counter when a branch falls through.
	localparam logic [xlen-1:0] instr_bytes = 32'd4;

	// Width of the raw branch offset field.
	localparam int branch_width = 12;

	// States of the branch stimulus FSM.
	localparam logic stim_idle = 1'b0;
	localparam logic stim_wait = 1'b1;

	// States of the execute FSM.
	// In exec_idle the stage waits for a decoded branch and resolves it,
	// in exec_commit it writes the program counter and signals completion.
	localparam logic exec_idle = 1'b0;
	localparam logic exec_commit = 1'b1;

endpackage

//--- verilog.f
src/fwrisc_pkg.sv
src/fwrisc_branch_stim.sv
src/fwrisc_exec_branch.sv
src/fwrisc_branch_top.sv
dv/fwrisc_branch_tb.sv
